/* verilog/mem_pkg.sv */
`default_nettype none

package mem_pkg;

  // Data path.
  localparam int xlen = 64;

  // Width of the operation code carried from decode.
  localparam int mem_op_len = 4;

  // Data RAM geometry. 1024 doublewords give 8 KiB.
  localparam int ram_addr_width = 10;
  localparam int lanes = 8;  // Bytes per RAM word.

  // Memory operation codes.
  typedef enum logic [mem_op_len-1:0] {
    mem_op_none = 4'd0,
    mem_op_lb   = 4'd1,
    mem_op_lbu  = 4'd2,
    mem_op_lh   = 4'd3,
    mem_op_lhu  = 4'd4,
    mem_op_lw   = 4'd5,
    mem_op_lwu  = 4'd6,
    mem_op_ld   = 4'd7,
    mem_op_sb   = 4'd8,
    mem_op_sh   = 4'd9,
    mem_op_sw   = 4'd10,
    mem_op_sd   = 4'd11
  } mem_op_t;

  // Access size as log2 of the byte count.
  typedef enum logic [1:0] {
    size_byte   = 2'd0,
    size_half   = 2'd1,
    size_word   = 2'd2,
    size_double = 2'd3
  } size_t;

endpackage

`default_nettype wire

/* verilog/mem_op_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_op_decode (
  input  mem_pkg::mem_op_t mem_op,
  input  logic [2:0]       addr_low,
  output logic             is_load,
  output logic             is_store,
  output logic             is_unsigned,
  output logic             aligned,
  output mem_pkg::size_t   size
);

  import mem_pkg::*;

  always_comb begin
    is_load     = 1'b0;
    is_store    = 1'b0;
    is_unsigned = 1'b0;
    size        = size_byte;

    case (mem_op)
      mem_op_lb: begin
        is_load = 1'b1;
      end
      mem_op_lbu: begin
        is_load     = 1'b1;
        is_unsigned = 1'b1;
      end
      mem_op_lh: begin
        is_load = 1'b1;
        size    = size_half;
      end
      mem_op_lhu: begin
        is_load     = 1'b1;
        is_unsigned = 1'b1;
        size        = size_half;
      end
      mem_op_lw: begin
        is_load = 1'b1;
        size    = size_word;
      end
      mem_op_lwu: begin
        is_load     = 1'b1;
        is_unsigned = 1'b1;
        size        = size_word;
      end
      mem_op_ld: begin
        is_load = 1'b1;
        size    = size_double;
      end
      mem_op_sb: is_store = 1'b1;
      mem_op_sh: begin
        is_store = 1'b1;
        size     = size_half;
      end
      mem_op_sw: begin
        is_store = 1'b1;
        size     = size_word;
      end
      mem_op_sd: begin
        is_store = 1'b1;
        size     = size_double;
      end
      default: ;  // mem_op_none and unused codes do nothing.
    endcase
  end

  // Low address bits below the access size must be zero.
  always_comb begin
    case (size)
      size_byte:   aligned = 1'b1;
      size_half:   aligned = (addr_low[0] == 1'b0);
      size_word:   aligned = (addr_low[1:0] == 2'b00);
      default:     aligned = (addr_low == 3'b000);
    endcase
  end

endmodule

`default_nettype wire

/* verilog/store_align.sv */
`timescale 1ns/1ps
`default_nettype none

module store_align (
  input  logic [mem_pkg::xlen-1:0]  store_data,
  input  mem_pkg::size_t            size,
  input  logic [2:0]                byte_offset,
  output logic [mem_pkg::xlen-1:0]  wdata,
  output logic [mem_pkg::lanes-1:0] wmask
);

  import mem_pkg::*;

  logic [lanes-1:0] base_mask;

  // Copy the low bytes into every lane of their width, so any
  // aligned offset already holds the right bytes.
  always_comb begin
    case (size)
      size_byte:   wdata = {8{store_data[7:0]}};
      size_half:   wdata = {4{store_data[15:0]}};
      size_word:   wdata = {2{store_data[31:0]}};
      default:     wdata = store_data;
    endcase
  end

  always_comb begin
    case (size)
      size_byte:   base_mask = 8'b0000_0001;
      size_half:   base_mask = 8'b0000_0011;
      size_word:   base_mask = 8'b0000_1111;
      default:     base_mask = 8'b1111_1111;
    endcase
  end

  // Mask starts at the addressed lane.
  assign wmask = base_mask << byte_offset;

endmodule

`default_nettype wire

/* verilog/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_ram (
  input  logic                               clock,
  input  logic                               we,
  input  logic                               re,
  input  logic [mem_pkg::ram_addr_width-1:0] index,
  input  logic [mem_pkg::xlen-1:0]           wdata,
  input  logic [mem_pkg::lanes-1:0]          wmask,
  output logic [mem_pkg::xlen-1:0]           rdata
);

  import mem_pkg::*;

  logic [xlen-1:0] mem [2 ** ram_addr_width];

  // Byte-lane writes.
  always_ff @(posedge clock) begin
    for (int i = 0; i < lanes; i++) begin
      if (we && wmask[i]) begin
        mem[index][i*8 +: 8] <= wdata[i*8 +: 8];
      end
    end
  end

  // Registered read port. Data appears the cycle after re.
  always_ff @(posedge clock) begin
    if (re) begin
      rdata <= mem[index];
    end
  end

endmodule

`default_nettype wire

/* verilog/load_align.sv */
`timescale 1ns/1ps
`default_nettype none

module load_align (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     load_start,
  input  mem_pkg::size_t           size,
  input  logic                     is_unsigned,
  input  logic [2:0]               byte_offset,
  input  logic [mem_pkg::xlen-1:0] rdata,
  output logic [mem_pkg::xlen-1:0] load_data,
  output logic                     load_valid
);

  import mem_pkg::*;

  logic            pending;
  size_t           size_q;
  logic            unsigned_q;
  logic [2:0]      offset_q;
  logic [xlen-1:0] shifted;
  logic            sign_bit;
  logic [xlen-1:0] extended;

  always_ff @(posedge clock) begin
    if (reset) begin
      pending <= 1'b0;
    end else begin
      pending <= load_start;
    end
  end

  // Side information follows the RAM read by one cycle.
  always_ff @(posedge clock) begin
    if (load_start) begin
      size_q     <= size;
      unsigned_q <= is_unsigned;
      offset_q   <= byte_offset;
    end
  end

  assign shifted = rdata >> {offset_q, 3'b000};  // Addressed byte to lane 0.

  always_comb begin
    case (size_q)
      size_byte:   sign_bit = shifted[7];
      size_half:   sign_bit = shifted[15];
      size_word:   sign_bit = shifted[31];
      default:     sign_bit = shifted[63];
    endcase
    if (unsigned_q) sign_bit = 1'b0;
  end

  always_comb begin
    case (size_q)
      size_byte:   extended = {{(xlen-8){sign_bit}}, shifted[7:0]};
      size_half:   extended = {{(xlen-16){sign_bit}}, shifted[15:0]};
      size_word:   extended = {{(xlen-32){sign_bit}}, shifted[31:0]};
      default:     extended = shifted;
    endcase
  end

  assign load_data  = pending ? extended : '0;  // Zero when nothing returns.
  assign load_valid = pending;

endmodule

`default_nettype wire

/* verilog/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     req,
  input  mem_pkg::mem_op_t         mem_op,
  input  logic [mem_pkg::xlen-1:0] addr,
  input  logic [mem_pkg::xlen-1:0] store_data,
  output logic [mem_pkg::xlen-1:0] load_data,
  output logic                     load_valid,
  output logic                     misaligned
);

  import mem_pkg::*;

  logic                      is_load;
  logic                      is_store;
  logic                      is_unsigned;
  logic                      aligned;
  size_t                     size;
  logic [2:0]                byte_offset;
  logic [ram_addr_width-1:0] ram_index;
  logic [xlen-1:0]           wdata;
  logic [lanes-1:0]          wmask;
  logic [xlen-1:0]           rdata;
  logic                      write_en;
  logic                      read_en;
  logic                      misaligned_q;

  assign byte_offset = addr[2:0];
  assign ram_index   = addr[ram_addr_width+2:3];  // Doubleword index.

  mem_op_decode u_decode (
    .mem_op      (mem_op),
    .addr_low    (byte_offset),
    .is_load     (is_load),
    .is_store    (is_store),
    .is_unsigned (is_unsigned),
    .aligned     (aligned),
    .size        (size)
  );

  store_align u_store_align (
    .store_data  (store_data),
    .size        (size),
    .byte_offset (byte_offset),
    .wdata       (wdata),
    .wmask       (wmask)
  );

  // Misaligned accesses touch nothing.
  assign write_en = req && is_store && aligned;
  assign read_en  = req && is_load && aligned;

  data_ram u_ram (
    .clock (clock),
    .we    (write_en),
    .re    (read_en),
    .index (ram_index),
    .wdata (wdata),
    .wmask (wmask),
    .rdata (rdata)
  );

  load_align u_load_align (
    .clock       (clock),
    .reset       (reset),
    .load_start  (read_en),
    .size        (size),
    .is_unsigned (is_unsigned),
    .byte_offset (byte_offset),
    .rdata       (rdata),
    .load_data   (load_data),
    .load_valid  (load_valid)
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      misaligned_q <= 1'b0;
    end else begin
      misaligned_q <= req && (is_load || is_store) && !aligned;
    end
  end

  assign misaligned = misaligned_q;  // Lines up with load_valid timing.

endmodule

`default_nettype wire

/* dv/mem_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage_tb;

  import mem_pkg::*;

  localparam int num_rows       = 40;
  localparam int fields         = 5;  // op, addr, store_data, load_data, misaligned.
  localparam int clock_period   = 100;
  localparam int timeout_cycles = num_rows + 20;

  localparam int field_op    = 0;
  localparam int field_addr  = 1;
  localparam int field_store = 2;
  localparam int field_load  = 3;
  localparam int field_mis   = 4;

  logic            clock = 1'b0;
  logic            reset;
  logic            req;
  mem_op_t         mem_op;
  logic [xlen-1:0] addr;
  logic [xlen-1:0] store_data;
  logic [xlen-1:0] load_data;
  logic            load_valid;
  logic            misaligned;

  logic [63:0] stim_mem [0:num_rows*fields-1];

  mem_stage u_dut (
    .clock      (clock),
    .reset      (reset),
    .req        (req),
    .mem_op     (mem_op),
    .addr       (addr),
    .store_data (store_data),
    .load_data  (load_data),
    .load_valid (load_valid),
    .misaligned (misaligned)
  );

  always #(clock_period / 2) clock = ~clock;

  task automatic check_value(
    input string       name,
    input logic [63:0] expected,
    input logic [63:0] actual
  );
    if (actual !== expected) begin
      $display("error at time %0t: %s expected %h, got %h", $time, name, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "Mismatch on %s.", name);
    end
  endtask

  // Puts one access from the stimulus table on the inputs.
  task automatic drive_access(input int row, input logic strobe);
    int base;
    base = row * fields;
    req        <= strobe;
    mem_op     <= mem_op_t'(stim_mem[base + field_op][3:0]);
    addr       <= stim_mem[base + field_addr];
    store_data <= stim_mem[base + field_store];
  endtask

  // Outputs one cycle after the req edge of the given row.
  task automatic verify_result(input int row);
    int          base;
    logic [3:0]  op_code;
    logic        exp_mis;
    logic        exp_valid;
    base      = row * fields;
    op_code   = stim_mem[base + field_op][3:0];
    exp_mis   = stim_mem[base + field_mis][0];
    // Only aligned loads return data.
    exp_valid = (op_code >= mem_op_lb) && (op_code <= mem_op_ld) && !exp_mis;
    check_value("load_valid", {63'd0, exp_valid}, {63'd0, load_valid});
    check_value("misaligned", {63'd0, exp_mis}, {63'd0, misaligned});
    check_value("load_data", stim_mem[base + field_load], load_data);
  endtask

  task automatic expect_quiet();
    check_value("load_valid", 64'd0, {63'd0, load_valid});
    check_value("misaligned", 64'd0, {63'd0, misaligned});
  endtask

  initial begin
    #(timeout_cycles * clock_period);
    $display("Watchdog expired before the stimulus table was finished.");
    $display("TEST FAIL");
    $fatal(1, "Timeout.");
  end

  initial begin
    reset      = 1'b1;
    req        = 1'b0;
    mem_op     = mem_op_none;
    addr       = '0;
    store_data = '0;

    $readmemh("dv/mem_stim.txt", stim_mem);
    if ($isunknown(stim_mem[num_rows*fields-1])) begin
      $display("Stimulus file dv/mem_stim.txt is missing or has fewer than %0d rows.",
               num_rows);
      $display("TEST FAIL");
      $fatal(1, "Bad stimulus file.");
    end

    repeat (4) @(posedge clock);
    reset <= 1'b0;

    // Quiet outputs right after reset.
    repeat (2) begin
      @(posedge clock);
      @(negedge clock);
      expect_quiet();
    end

    for (int row = 0; row < num_rows; row++) begin
      @(posedge clock);
      drive_access(row, 1'b1);
      if (row > 0) begin
        @(negedge clock);
        verify_result(row - 1);
      end
    end

    // Row 37 is an aligned load, row 36 a misaligned one. Both go in with req low.
    @(posedge clock);
    drive_access(37, 1'b0);
    @(negedge clock);
    verify_result(num_rows - 1);

    @(posedge clock);
    drive_access(36, 1'b0);
    @(negedge clock);
    expect_quiet();  // No read without req.

    @(posedge clock);
    mem_op <= mem_op_none;
    @(negedge clock);
    expect_quiet();  // No misaligned flag without req.

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/mem_stim.txt */
// Columns: op addr store_data expected_load_data expected_misaligned (all hex)
// op: 0 none, 1 lb, 2 lbu, 3 lh, 4 lhu, 5 lw, 6 lwu, 7 ld, 8 sb, 9 sh, a sw, b sd
b 0200 0123456789abcdef 0000000000000000 0
8 0200 ffffffffffffff11 0000000000000000 0
8 0202 0000000000000033 0000000000000000 0
8 0205 1234567890abcd66 0000000000000000 0
8 0207 0000000000000088 0000000000000000 0
7 0200 0000000000000000 882366678933cd11 0
8 0201 0000000000000022 0000000000000000 0
8 0203 0000000000000044 0000000000000000 0
8 0204 0000000000000055 0000000000000000 0
8 0206 0000000000000077 0000000000000000 0
7 0200 0000000000000000 8877665544332211 0
b 0208 ffffffffffffffff 0000000000000000 0
9 0208 123456789abca1a0 0000000000000000 0
9 020c 00000000ffffb1b0 0000000000000000 0
7 0208 0000000000000000 ffffb1b0ffffa1a0 0
9 020a 000000000000c1c0 0000000000000000 0
9 020e 55555555aaaad1d0 0000000000000000 0
7 0208 0000000000000000 d1d0b1b0c1c0a1a0 0
b 0210 0000000000000000 0000000000000000 0
a 0214 55555555f00dcafe 0000000000000000 0
7 0210 0000000000000000 f00dcafe00000000 0
a 0210 aaaaaaaa80000001 0000000000000000 0
7 0210 0000000000000000 f00dcafe80000001 0
1 0207 0000000000000000 ffffffffffffff88 0
2 0207 0000000000000000 0000000000000088 0
3 020e 0000000000000000 ffffffffffffd1d0 0
4 020e 0000000000000000 000000000000d1d0 0
5 0210 0000000000000000 ffffffff80000001 0
6 0210 0000000000000000 0000000080000001 0
5 0214 0000000000000000 fffffffff00dcafe 0
7 0208 0000000000000000 d1d0b1b0c1c0a1a0 0
1 0201 0000000000000000 0000000000000022 0
9 0201 000000000000ffff 0000000000000000 1
5 0202 0000000000000000 0000000000000000 1
b 0204 0000000000000000 0000000000000000 1
7 0209 0000000000000000 0000000000000000 1
4 0203 0000000000000000 0000000000000000 1
7 0200 0000000000000000 8877665544332211 0
0 0000 0000000000000000 0000000000000000 0
0 1ff8 ffffffffffffffff 0000000000000000 0

/* compile.f */
verilog/mem_pkg.sv
verilog/mem_op_decode.sv
verilog/store_align.sv
verilog/data_ram.sv
verilog/load_align.sv
verilog/mem_stage.sv
dv/mem_stage_tb.sv

/* Bender.yml */
package:
  name: mem_stage

sources:
  - verilog/mem_pkg.sv
  - verilog/mem_op_decode.sv
  - verilog/store_align.sv
  - verilog/data_ram.sv
  - verilog/load_align.sv
  - verilog/mem_stage.sv
  - target: simulation
    files:
      - dv/mem_stage_tb.sv

# Simulation top: mem_stage_tb, run from the project root so that
# dv/mem_stim.txt is found.
# Synthesis top: mem_stage.
